// ==== bench/panel_tb.sv ====
`timescale 1ns/10ps

module panel_tb;

	import panel_pkg::*;

	localparam int clk_period = 4;
	localparam int test_slots = 250;
	localparam int watchdog_slots = 400;

	logic clock_1us;
	logic rst_n;
	logic wr_valid;
	logic wr_ready;
	reg_addr_t wr_addr;
	reg_data_t wr_data;
	logic [key_cols-1:0] key_col;
	logic [key_rows_n-1:0] key_rows;
	logic key_valid;
	logic key_ready;
	key_code_t key_code;
	bcd_t cathode;
	anode_t anode;
	ms_addr_t ms_addr;
	ms_char_t ms_data;
	logic ms_wr_addr_n;
	logic ms_wr_data_n;

	integer seed = 32'hc5201a3e;
	int writes_done = 0;

	// The one key that the operator holds
	logic key_held;
	logic [1:0] held_col;
	logic [1:0] held_row;

	// Reference model of the panel
	bcd_t exp_digits [nixie_digits] = '{default: 4'd15};
	ms_char_t exp_chars [ms_positions] = '{default: 8'h20};
	logic [key_rows_n-1:0] row_hist [key_cols] = '{default: '0};
	logic exp_run = 1'b0;
	int tube_idx = 0;
	int pos = 0;
	int col = key_cols - 1;
	logic pending = 1'b0;
	key_code_t pending_code;
	anode_t prev_anode = '0;
	logic [9:0] ready_hist = '0;
	int cycle_cnt = 0;
	int last_data_time = -1;
	int run_on = 0;
	int run_off = slot_cycles + 1;
	int rd_wait = 0;
	int ms_writes = 0;
	int events_taken = 0;
	bcd_t exp_cathode;
	logic [key_rows_n-1:0] rows_exp;
	logic [key_rows_n-1:0] pressed;
	int gap;

	panel_top dut_i (.*);

	// Rows follow the column drive through the held key
	assign key_rows = (key_held && key_col[held_col]) ? 4'(1 << held_row) : '0;

	always #(clk_period / 2) clock_1us = !clock_1us;

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual) else begin
			report_fail($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
		end
	endtask

	function automatic int lowest_row(input logic [key_rows_n-1:0] rows);
		for (int r = 0; r < key_rows_n; r++) begin
			if (rows[r]) begin
				return r;
			end
		end
		return 0;
	endfunction

	// Valid/ready write, the request holds until it is taken
	task automatic host_write(input reg_addr_t addr, input reg_data_t data);
		@(posedge clock_1us);
		wr_valid <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
		do begin
			@(negedge clock_1us);
		end while (!(wr_valid && wr_ready));
		@(posedge clock_1us);
		wr_valid <= 1'b0;
	endtask

	task automatic random_write();
		int kind;
		reg_addr_t addr;
		kind = $unsigned($random(seed)) % 8;
		if (kind < 3) begin
			addr = reg_addr_t'($unsigned($random(seed)) % nixie_digits);
		end else if (kind < 7) begin
			addr = reg_char_base + reg_addr_t'($unsigned($random(seed)) % ms_positions);
		end else begin
			// Unused, above the control register
			addr = reg_addr_t'(33 + $unsigned($random(seed)) % 31);
		end
		host_write(addr, reg_data_t'($random(seed)));
	endtask

	// Scoreboard at the falling edge, where all outputs have settled
	always @(negedge clock_1us) begin
		if (rst_n) begin
			cycle_cnt++;
			run_on = exp_run ? run_on + 1 : 0;
			run_off = exp_run ? 0 : run_off + 1;
			if (run_off > slot_cycles) begin
				assert (ms_wr_addr_n && ms_wr_data_n && anode == prev_anode) else begin
					report_fail("ERROR display bus or tubes moved while run was off");
				end
			end
			// A new anode means the next tube, its cathode was latched just before
			if (anode != prev_anode) begin
				exp_cathode = (exp_digits[tube_idx] > 9) ? 4'd15 : exp_digits[tube_idx];
				check_value("anode", 1 << tube_idx, anode);
				check_value("cathode", exp_cathode, cathode);
				tube_idx = (tube_idx + 1) % nixie_digits;
			end
			check_value("key_valid", pending, key_valid);
			if (pending) begin
				check_value("key_code", pending_code, key_code);
			end
			pressed = '0;
			if (rd_wait > 0) begin
				rd_wait--;
				if (rd_wait == 0) begin
					rows_exp = (key_held && held_col == col) ? 4'(1 << held_row) : '0;
					pressed = rows_exp & ~row_hist[col];
					row_hist[col] = rows_exp;
				end
			end
			if (pending && key_ready) begin
				pending = 1'b0;
				events_taken++;
			end else if (pressed != 0 && !pending) begin
				pending = 1'b1;
				pending_code = key_code_t'(col * key_rows_n + lowest_row(pressed));
			end
			// Address strobe in slot cycle 8, data strobe in slot cycle 10
			if (!ms_wr_addr_n) begin
				check_value("ms_addr", pos, ms_addr);
				col = (col + 1) % key_cols;
				check_value("key_col", 1 << col, key_col);
			end
			if (!ms_wr_data_n) begin
				check_value("ms_data", exp_chars[pos], ms_data);
				check_value("busy_window", 0, ready_hist);
				check_value("ready_after_busy", 1, wr_ready);
				gap = cycle_cnt - last_data_time;
				if (last_data_time >= 0 && run_on > gap) begin
					check_value("slot_period", slot_cycles, gap);
				end
				pos = (pos + 1) % ms_positions;
				last_data_time = cycle_cnt;
				ms_writes++;
				// Row read in slot cycle 13
				rd_wait = 3;
			end
			// Accepted writes reach the DUT registers at the next edge
			if (wr_valid && wr_ready) begin
				if (wr_addr < nixie_digits) begin
					exp_digits[wr_addr] = wr_data[3:0];
				end else if (wr_addr >= reg_char_base &&
					wr_addr < reg_char_base + ms_positions) begin
					exp_chars[wr_addr - reg_char_base] = wr_data;
				end else if (wr_addr == reg_ctrl_addr) begin
					exp_run = wr_data[0];
				end
			end
			ready_hist = {ready_hist[8:0], wr_ready};
			prev_anode = anode;
		end
	end

	initial begin
		clock_1us = 1'b0;
		rst_n = 1'b0;
		wr_valid = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		key_ready = 1'b0;
		key_held = 1'b0;
		held_col = '0;
		held_row = '0;
		repeat (5) @(posedge clock_1us);
		rst_n <= 1'b1;
		@(negedge clock_1us);
		check_value("reset_state", {1'b1, 1'b1, 6'd0, 4'd15, 1'b0, 1'b1, 4'd0},
			{ms_wr_addr_n, ms_wr_data_n, anode, cathode, key_valid, wr_ready, key_col});
		// Host traffic while the scan is stopped
		repeat (12) begin
			random_write();
		end
		host_write(reg_ctrl_addr, 8'h01);
		while (cycle_cnt < test_slots * slot_cycles) begin
			random_write();
			writes_done++;
			if (writes_done % 150 == 0) begin
				host_write(reg_ctrl_addr, 8'h00);
				repeat (3 * slot_cycles) @(posedge clock_1us);
				host_write(reg_ctrl_addr, 8'h01);
			end
			repeat ($unsigned($random(seed)) % 4) @(posedge clock_1us);
		end
		repeat (4 * slot_cycles) @(negedge clock_1us);
		assert (ms_writes > 0 && events_taken > 0) else begin
			report_fail("ERROR the scan produced no display writes or no key events");
		end
		$display("TB PASSED");
		$finish;
	end

	// Operator presses and releases one random key at a time
	initial begin
		int hold;
		@(posedge rst_n);
		forever begin
			hold = 64 + $unsigned($random(seed)) % 96;
			repeat (hold) @(posedge clock_1us);
			if (!key_held) begin
				held_col <= 2'($random(seed));
				held_row <= 2'($random(seed));
			end
			key_held <= !key_held;
		end
	end

	// Random back-pressure on key events
	always @(posedge clock_1us) begin
		key_ready <= ($random(seed) % 2) != 0;
	end

	initial begin
		#(watchdog_slots * slot_cycles * clk_period);
		$display("ERROR watchdog expired, the test did not end within %0d slots", watchdog_slots);
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

endmodule

// ==== src.f ====
verilog/panel_pkg.sv
verilog/panel_sequencer.sv
verilog/panel_regs.sv
verilog/nixie_scan.sv
verilog/key_matrix.sv
verilog/ms6205_writer.sv
verilog/panel_top.sv
bench/panel_tb.sv

// ==== verilog/key_matrix.sv ====
`timescale 1ns/10ps

module key_matrix (
	input  logic clock_1us,
	input  logic rst_n,
	input  logic key_col_wr,
	input  logic key_rd,
	output logic [panel_pkg::key_cols-1:0] key_col,
	input  logic [panel_pkg::key_rows_n-1:0] key_rows,
	output logic key_valid,
	input  logic key_ready,
	output panel_pkg::key_code_t key_code
);

	import panel_pkg::*;

	logic [$clog2(key_cols)-1:0] col_idx;
	logic [$clog2(key_cols)-1:0] col_next;
	logic [key_rows_n-1:0] last_rows [key_cols];
	logic [key_rows_n-1:0] pressed;
	logic [$clog2(key_rows_n)-1:0] press_row;
	logic new_event;

	assign col_next = (col_idx == key_cols - 1) ? '0 : col_idx + 1'b1;

	// Rows are active high, pressed now but up on the last visit to this column
	assign pressed = key_rows & ~last_rows[col_idx];

	// Lowest numbered row wins
	always_comb begin
		press_row = '0;
		for (int r = key_rows_n - 1; r >= 0; r--) begin
			if (pressed[r]) begin
				press_row = r[$clog2(key_rows_n)-1:0];
			end
		end
	end

	// Presses are lost while an event waits
	assign new_event = key_rd && |pressed && !key_valid;

	// Column driver, the first advance after reset lands on column 0
	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			col_idx <= '1;
			key_col <= '0;
		end else if (key_col_wr) begin
			col_idx <= col_next;
			key_col <= {{(key_cols-1){1'b0}}, 1'b1} << col_next;
		end
	end

	// Row history per column
	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			for (int c = 0; c < key_cols; c++) begin
				last_rows[c] <= '0;
			end
		end else if (key_rd) begin
			last_rows[col_idx] <= key_rows;
		end
	end

	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			key_valid <= 1'b0;
		end else if (key_valid && key_ready) begin
			key_valid <= 1'b0;
		end else if (new_event) begin
			key_valid <= 1'b1;
		end
	end

	always_ff @(posedge clock_1us) begin
		if (new_event) begin
			key_code <= {col_idx, press_row};
		end
	end

	a_code_hold: assert property (@(posedge clock_1us) disable iff (!rst_n)
		(key_valid && !key_ready) |=> (key_valid && $stable(key_code)));

endmodule

// ==== verilog/ms6205_writer.sv ====
`timescale 1ns/10ps

module ms6205_writer (
	input  logic clock_1us,
	input  logic rst_n,
	input  logic ms_addr_wr,
	input  logic ms_data_wr,
	input  panel_pkg::ms_char_t [panel_pkg::ms_positions-1:0] chars,
	output panel_pkg::ms_addr_t ms_addr,
	output panel_pkg::ms_char_t ms_data,
	output logic ms_wr_addr_n,
	output logic ms_wr_data_n
);

	import panel_pkg::*;

	// Display position written in the current slot
	ms_addr_t pos;

	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			pos <= '0;
			ms_wr_addr_n <= 1'b1;
			ms_wr_data_n <= 1'b1;
		end else begin
			// Bus strobes low for one cycle after each sequencer strobe
			ms_wr_addr_n <= !ms_addr_wr;
			ms_wr_data_n <= !ms_data_wr;
			if (ms_data_wr) begin
				pos <= (pos == ms_addr_t'(ms_positions - 1)) ? '0 : pos + 1'b1;
			end
		end
	end

	// Address and data bus
	always_ff @(posedge clock_1us) begin
		if (ms_addr_wr) begin
			ms_addr <= pos;
		end
		if (ms_data_wr) begin
			ms_data <= chars[pos];
		end
	end

	// Data write always follows its address write two cycles later
	a_addr_first: assert property (@(posedge clock_1us) disable iff (!rst_n)
		$fell(ms_wr_data_n) |-> $past(!ms_wr_addr_n, 2));

endmodule

// ==== verilog/nixie_scan.sv ====
`timescale 1ns/10ps

module nixie_scan (
	input  logic clock_1us,
	input  logic rst_n,
	input  logic cathode_wr,
	input  logic anode_wr,
	input  panel_pkg::bcd_t [panel_pkg::nixie_digits-1:0] digits,
	output panel_pkg::bcd_t cathode,
	output panel_pkg::anode_t anode
);

	import panel_pkg::*;

	logic [$clog2(nixie_digits)-1:0] tube_idx;
	logic [$clog2(nixie_digits)-1:0] tube_idx_next;
	bcd_t tube_digit;

	assign tube_digit = digits[tube_idx];
	assign tube_idx_next = (tube_idx == nixie_digits - 1) ? '0 : tube_idx + 1'b1;

	// Cathode latch
	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			cathode <= bcd_blank;
		end else if (cathode_wr) begin
			// No cathode for codes above 9
			cathode <= (tube_digit > 4'd9) ? bcd_blank : tube_digit;
		end
	end

	// Anode latch moves on to the next tube
	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			anode <= '0;
			tube_idx <= '0;
		end else if (anode_wr) begin
			anode <= anode_t'(1) << tube_idx;
			tube_idx <= tube_idx_next;
		end
	end

	a_anode_onehot: assert property (@(posedge clock_1us) disable iff (!rst_n)
		$onehot0(anode));

endmodule

// ==== verilog/panel_pkg.sv ====
package panel_pkg;

	// Panel geometry
	localparam int nixie_digits = 6;
	localparam int key_cols = 4;
	localparam int key_rows_n = 4;
	localparam int ms_positions = 16;

	// Scan slot timing in clock_1us cycles
	localparam int slot_on_cycles = 12;
	localparam int slot_off_cycles = 4;
	localparam int slot_cycles = slot_on_cycles + slot_off_cycles;

	typedef logic [3:0] bcd_t;
	typedef logic [5:0] anode_t;
	typedef logic [3:0] key_code_t;
	typedef logic [3:0] ms_addr_t;
	typedef logic [7:0] ms_char_t;
	typedef logic [5:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Cathode code with no tube segment, the tube stays dark
	localparam bcd_t bcd_blank = 4'd15;
	localparam ms_char_t ms_char_space = 8'h20;

	// Host register map
	localparam reg_addr_t reg_char_base = 6'd16;
	localparam reg_addr_t reg_ctrl_addr = 6'd32;

	// Strobe sequencer stages, same codes as the panel's original sequencer
	typedef enum logic [2:0] {
		idle        = 3'd0,
		cathodes    = 3'd1,
		anodes      = 3'd2,
		keyboard_wr = 3'd3,
		mc_addr     = 3'd4,
		mc_data     = 3'd5,
		keyboard_rd = 3'd6,
		stop        = 3'd7
	} seq_state_t;

endpackage

// ==== verilog/panel_regs.sv ====
`timescale 1ns/10ps

module panel_regs (
	input  logic clock_1us,
	input  logic rst_n,
	input  logic wr_valid,
	output logic wr_ready,
	input  panel_pkg::reg_addr_t wr_addr,
	input  panel_pkg::reg_data_t wr_data,
	input  logic busy,
	output logic run,
	output panel_pkg::bcd_t [panel_pkg::nixie_digits-1:0] digits,
	output panel_pkg::ms_char_t [panel_pkg::ms_positions-1:0] chars
);

	import panel_pkg::*;

	logic wr_fire;
	logic hit_digit;
	logic hit_char;
	logic hit_ctrl;
	logic [$clog2(nixie_digits)-1:0] digit_sel;
	ms_addr_t char_sel;

	// Host is held off while the sequencer walks its write stages
	assign wr_ready = !busy;
	assign wr_fire = wr_valid && wr_ready;

	// Address decode
	assign hit_digit = wr_addr < reg_addr_t'(nixie_digits);
	assign hit_char = (wr_addr >= reg_char_base) &&
		(wr_addr < reg_char_base + reg_addr_t'(ms_positions));
	assign hit_ctrl = (wr_addr == reg_ctrl_addr);

	assign digit_sel = wr_addr[$clog2(nixie_digits)-1:0];
	assign char_sel = ms_addr_t'(wr_addr - reg_char_base);

	// Unused addresses are accepted and dropped
	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			run <= 1'b0;
			digits <= {nixie_digits{bcd_blank}};
			chars <= {ms_positions{ms_char_space}};
		end else if (wr_fire) begin
			if (hit_digit) begin
				digits[digit_sel] <= wr_data[3:0];
			end
			if (hit_char) begin
				chars[char_sel] <= wr_data;
			end
			if (hit_ctrl) begin
				run <= wr_data[0];
			end
		end
	end

	// Scan blocks see steady registers through the write stages
	a_hold_busy: assert property (@(posedge clock_1us) disable iff (!rst_n)
		busy |=> ($stable(digits) && $stable(chars) && $stable(run)));

endmodule

// ==== verilog/panel_sequencer.sv ====
`timescale 1ns/10ps

module panel_sequencer (
	input  logic clock_1us,
	input  logic rst_n,
	input  logic run,
	output logic cathode_wr,
	output logic anode_wr,
	output logic key_col_wr,
	output logic ms_addr_wr,
	output logic ms_data_wr,
	output logic key_rd,
	output logic busy
);

	import panel_pkg::*;

	logic [$clog2(slot_cycles)-1:0] slot_cnt;
	logic [$clog2(slot_cycles)-1:0] slot_cnt_next;
	logic slot_active;
	logic slot_active_next;
	logic slot_en;
	logic slot_en_next;
	seq_state_t state;
	seq_state_t state_next;

	// Slot timer, a new slot is only started while run is set
	always_comb begin
		if (!slot_active || slot_cnt == slot_cycles - 1) begin
			slot_active_next = run;
			slot_cnt_next = '0;
		end else begin
			slot_active_next = 1'b1;
			slot_cnt_next = slot_cnt + 1'b1;
		end
	end

	assign slot_en = slot_active && (slot_cnt < slot_on_cycles);
	// Look-ahead so that stage changes line up with the enable edges
	assign slot_en_next = slot_active_next && (slot_cnt_next < slot_on_cycles);

	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			slot_active <= 1'b0;
			slot_cnt <= '0;
		end else begin
			slot_active <= slot_active_next;
			slot_cnt <= slot_cnt_next;
		end
	end

	// Each write stage is left once its own strobe has fired
	always_comb begin
		unique case (state)
			idle:        state_next = slot_en_next ? cathodes : idle;
			cathodes:    state_next = cathode_wr ? anodes : cathodes;
			anodes:      state_next = anode_wr ? keyboard_wr : anodes;
			keyboard_wr: state_next = key_col_wr ? mc_addr : keyboard_wr;
			mc_addr:     state_next = ms_addr_wr ? mc_data : mc_addr;
			mc_data:     state_next = ms_data_wr ? stop : mc_data;
			stop:        state_next = slot_en_next ? stop : keyboard_rd;
			keyboard_rd: state_next = key_rd ? idle : keyboard_rd;
			default:     state_next = idle;
		endcase
	end

	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			state <= state_next;
		end
	end

	// Strobes come in the second cycle of a stage and last one cycle
	always_ff @(posedge clock_1us) begin
		if (!rst_n) begin
			cathode_wr <= 1'b0;
			anode_wr <= 1'b0;
			key_col_wr <= 1'b0;
			ms_addr_wr <= 1'b0;
			ms_data_wr <= 1'b0;
			key_rd <= 1'b0;
		end else begin
			cathode_wr <= (state == cathodes) && slot_en && !cathode_wr;
			anode_wr <= (state == anodes) && slot_en && !anode_wr;
			key_col_wr <= (state == keyboard_wr) && slot_en && !key_col_wr;
			ms_addr_wr <= (state == mc_addr) && slot_en && !ms_addr_wr;
			ms_data_wr <= (state == mc_data) && slot_en && !ms_data_wr;
			// Row read happens in the idle half of the slot
			key_rd <= (state == keyboard_rd) && !slot_en && !key_rd;
		end
	end

	assign busy = state inside {cathodes, anodes, keyboard_wr, mc_addr, mc_data};

	a_one_strobe: assert property (@(posedge clock_1us) disable iff (!rst_n)
		$onehot0({cathode_wr, anode_wr, key_col_wr, ms_addr_wr, ms_data_wr, key_rd}));

	a_busy_free: assert property (@(posedge clock_1us) disable iff (!rst_n)
		(state inside {stop, keyboard_rd}) |-> !busy);

	// Row read lands four cycles after the last display write
	a_read_after_write: assert property (@(posedge clock_1us) disable iff (!rst_n)
		ms_data_wr |-> ##4 key_rd);

endmodule

// ==== verilog/panel_top.sv ====
`timescale 1ns/10ps

module panel_top (
	input  logic clock_1us,
	input  logic rst_n,
	input  logic wr_valid,
	output logic wr_ready,
	input  panel_pkg::reg_addr_t wr_addr,
	input  panel_pkg::reg_data_t wr_data,
	output logic [panel_pkg::key_cols-1:0] key_col,
	input  logic [panel_pkg::key_rows_n-1:0] key_rows,
	output logic key_valid,
	input  logic key_ready,
	output panel_pkg::key_code_t key_code,
	output panel_pkg::bcd_t cathode,
	output panel_pkg::anode_t anode,
	output panel_pkg::ms_addr_t ms_addr,
	output panel_pkg::ms_char_t ms_data,
	output logic ms_wr_addr_n,
	output logic ms_wr_data_n
);

	import panel_pkg::*;

	logic run;
	logic busy;
	bcd_t [nixie_digits-1:0] digits;
	ms_char_t [ms_positions-1:0] chars;

	// Sequencer strobes
	logic cathode_wr;
	logic anode_wr;
	logic key_col_wr;
	logic ms_addr_wr;
	logic ms_data_wr;
	logic key_rd;

	panel_regs regs_i (
		.clock_1us (clock_1us),
		.rst_n     (rst_n),
		.wr_valid  (wr_valid),
		.wr_ready  (wr_ready),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.busy      (busy),
		.run       (run),
		.digits    (digits),
		.chars     (chars)
	);

	panel_sequencer seq_i (
		.clock_1us  (clock_1us),
		.rst_n      (rst_n),
		.run        (run),
		.cathode_wr (cathode_wr),
		.anode_wr   (anode_wr),
		.key_col_wr (key_col_wr),
		.ms_addr_wr (ms_addr_wr),
		.ms_data_wr (ms_data_wr),
		.key_rd     (key_rd),
		.busy       (busy)
	);

	nixie_scan nixie_i (
		.clock_1us  (clock_1us),
		.rst_n      (rst_n),
		.cathode_wr (cathode_wr),
		.anode_wr   (anode_wr),
		.digits     (digits),
		.cathode    (cathode),
		.anode      (anode)
	);

	key_matrix keys_i (
		.clock_1us  (clock_1us),
		.rst_n      (rst_n),
		.key_col_wr (key_col_wr),
		.key_rd     (key_rd),
		.key_col    (key_col),
		.key_rows   (key_rows),
		.key_valid  (key_valid),
		.key_ready  (key_ready),
		.key_code   (key_code)
	);

	ms6205_writer ms_i (
		.clock_1us    (clock_1us),
		.rst_n        (rst_n),
		.ms_addr_wr   (ms_addr_wr),
		.ms_data_wr   (ms_data_wr),
		.chars        (chars),
		.ms_addr      (ms_addr),
		.ms_data      (ms_data),
		.ms_wr_addr_n (ms_wr_addr_n),
		.ms_wr_data_n (ms_wr_data_n)
	);

endmodule
